// File: src/keypad_pkg.sv
`default_nettype none

package keypad_pkg;

    typedef logic [31:0] data_word_t;       // entered value and apb data
    typedef logic [7:0]  key_code_t;        // {row, col}, both active low
    typedef logic [3:0]  digit_count_t;
    typedef logic [3:0]  apb_addr_t;

    localparam digit_count_t max_digits = 4'd10;

    localparam key_code_t key_zero      = 8'b0111_1101;
    localparam key_code_t key_one       = 8'b1110_1110;
    localparam key_code_t key_two       = 8'b1110_1101;
    localparam key_code_t key_three     = 8'b1110_1011;
    localparam key_code_t key_four      = 8'b1101_1110;
    localparam key_code_t key_five      = 8'b1101_1101;
    localparam key_code_t key_six       = 8'b1101_1011;
    localparam key_code_t key_seven     = 8'b1011_1110;
    localparam key_code_t key_eight     = 8'b1011_1101;
    localparam key_code_t key_nine      = 8'b1011_1011;
    localparam key_code_t key_backspace = 8'b0111_1110;   // "*"
    localparam key_code_t key_enter     = 8'b0111_1011;   // "#"
    localparam key_code_t key_pause     = 8'b1110_0111;   // "A"
    localparam key_code_t key_switch    = 8'b1101_0111;   // "B"

    localparam apb_addr_t addr_ctrl   = 4'h0;
    localparam apb_addr_t addr_status = 4'h4;
    localparam apb_addr_t addr_data   = 4'h8;

    typedef enum logic [1:0] {
        st_block,
        st_switch,
        st_keypad,
        st_pause
    } entry_state_t;

    // digit value of a key, 4'hf for every key that is not a digit
    function automatic logic [3:0] key_digit(input key_code_t code);
        case (code)
            key_zero:  return 4'd0;
            key_one:   return 4'd1;
            key_two:   return 4'd2;
            key_three: return 4'd3;
            key_four:  return 4'd4;
            key_five:  return 4'd5;
            key_six:   return 4'd6;
            key_seven: return 4'd7;
            key_eight: return 4'd8;
            key_nine:  return 4'd9;
            default:   return 4'hf;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: src/keypad_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_scanner #(
    parameter int scan_div       = 1000,
    parameter int debounce_scans = 3
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [3:0]            kp_row,
    output logic [3:0]            kp_col,
    output logic                  key_valid,
    output keypad_pkg::key_code_t key_code
);
    import keypad_pkg::*;

    localparam int div_w   = $clog2(scan_div + 1);
    localparam int match_w = $clog2(debounce_scans + 1);

    logic [div_w-1:0]   div_cnt;
    logic               step_end;       // last clock of the current column
    logic               scan_end;       // last clock of column 3
    logic               row_hit;
    logic               scan_found;     // key already seen earlier in this scan
    logic               scan_has_key;
    key_code_t          scan_code;      // first key of the running scan
    key_code_t          this_code;
    key_code_t          prev_code;      // key seen by the previous scan
    logic               prev_valid;
    logic               same_key;
    logic [match_w-1:0] match_cnt;
    logic [match_w-1:0] next_match;
    logic               armed;          // cleared after a pulse until an empty scan

    assign step_end     = (div_cnt == div_w'(scan_div - 1));
    assign scan_end     = step_end && (kp_col == 4'b0111);
    assign row_hit      = (kp_row != 4'b1111);
    assign scan_has_key = scan_found || row_hit;
    assign this_code    = scan_found ? scan_code : {kp_row, kp_col};
    assign same_key     = prev_valid && (this_code == prev_code);

    // saturating count of identical scans
    always_comb begin
        if (!same_key) begin
            next_match = match_w'(1);
        end else if (match_cnt == match_w'(debounce_scans)) begin
            next_match = match_cnt;
        end else begin
            next_match = match_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt    <= '0;
            kp_col     <= 4'b1110;
            scan_found <= 1'b0;
            prev_valid <= 1'b0;
            match_cnt  <= '0;
            armed      <= 1'b1;
            key_valid  <= 1'b0;
        end else begin
            key_valid <= 1'b0;
            if (step_end) begin
                div_cnt <= '0;
                kp_col  <= {kp_col[2:0], kp_col[3]};   // low bit walks left
                if (scan_end) begin
                    scan_found <= 1'b0;
                    if (scan_has_key) begin
                        prev_valid <= 1'b1;
                        match_cnt  <= next_match;
                        if (armed && (next_match == match_w'(debounce_scans))) begin
                            key_valid <= 1'b1;
                            armed     <= 1'b0;
                        end
                    end else begin
                        prev_valid <= 1'b0;   // empty scan releases the key
                        match_cnt  <= '0;
                        armed      <= 1'b1;
                    end
                end else if (row_hit) begin
                    scan_found <= 1'b1;
                end
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step_end && row_hit && !scan_found) begin
            scan_code <= {kp_row, kp_col};
        end
        if (scan_end && scan_has_key) begin
            prev_code <= this_code;
            key_code  <= this_code;   // lines up with key_valid
        end
    end

    a_one_column: assert property (@(posedge clk) disable iff (!rst_n) $onehot(~kp_col))
        else $error("kp_col strobes %b, not a single column", kp_col);

endmodule

`default_nettype wire

// File: src/decimal_entry.sv
`timescale 1ns/1ps
`default_nettype none

module decimal_entry (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     key_valid,
    input  keypad_pkg::key_code_t    key_code,
    input  logic                     input_request,
    input  logic                     ignore_pause,
    output logic                     input_complete,
    output logic                     switch_enable,
    output logic                     cpu_pause,
    output keypad_pkg::digit_count_t digit_count,
    output keypad_pkg::data_word_t   keypad_data,
    output logic                     overflow_9th,
    output logic                     overflow_10th
);
    import keypad_pkg::*;

    entry_state_t state;
    entry_state_t resume_state;   // where "A" returns to
    logic [3:0]   digit_val;
    logic         is_digit;
    logic         is_backspace;
    logic         is_enter;
    logic         is_pause;
    logic         is_switch;

    assign digit_val    = key_digit(key_code);
    assign is_digit     = key_valid && (digit_val != 4'hf);
    assign is_backspace = key_valid && (key_code == key_backspace);
    assign is_enter     = key_valid && (key_code == key_enter);
    assign is_pause     = key_valid && (key_code == key_pause);
    assign is_switch    = key_valid && (key_code == key_switch);

    assign overflow_9th  = (digit_count >= 4'd9);
    assign overflow_10th = (digit_count == max_digits);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state          <= st_block;
            resume_state   <= st_block;
            input_complete <= 1'b0;
            switch_enable  <= 1'b0;
            cpu_pause      <= 1'b0;
            digit_count    <= '0;
            keypad_data    <= '0;
        end else begin
            case (state)
                st_block: begin
                    if (is_pause) begin
                        resume_state <= st_block;
                        state        <= st_pause;
                        cpu_pause    <= 1'b1;
                    end else if (input_request) begin
                        state          <= st_keypad;
                        input_complete <= 1'b0;
                        keypad_data    <= '0;   // fresh number per request
                    end
                end
                st_keypad: begin
                    if (is_switch) begin
                        state         <= st_switch;
                        switch_enable <= 1'b1;
                    end else if (is_backspace) begin
                        if (digit_count != '0) begin
                            keypad_data <= keypad_data / 32'd10;
                            digit_count <= digit_count - 1'b1;
                        end
                    end else if (is_enter) begin
                        state          <= st_block;
                        input_complete <= 1'b1;
                        digit_count    <= '0;
                    end else if (is_pause) begin
                        resume_state <= st_keypad;
                        state        <= st_pause;
                        cpu_pause    <= 1'b1;
                    end else if (is_digit && (digit_count < max_digits)) begin
                        // wraps modulo 2^32 on long entries
                        keypad_data <= keypad_data * 32'd10 + {28'b0, digit_val};
                        digit_count <= digit_count + 1'b1;
                    end
                end
                st_switch: begin
                    if (is_switch) begin
                        state         <= st_keypad;
                        switch_enable <= 1'b0;
                    end else if (is_enter) begin
                        state          <= st_block;
                        input_complete <= 1'b1;
                        digit_count    <= '0;
                    end else if (is_pause) begin
                        resume_state <= st_switch;
                        state        <= st_pause;
                        cpu_pause    <= 1'b1;
                    end
                end
                st_pause: begin
                    if (is_pause && !ignore_pause) begin
                        state     <= resume_state;
                        cpu_pause <= 1'b0;
                    end
                end
                default: begin
                    state <= st_block;
                end
            endcase
        end
    end

    a_count_limit: assert property (@(posedge clk) disable iff (!rst_n)
        digit_count <= max_digits)
        else $error("digit_count %0d above limit", digit_count);

    // pause flag and pause state move on the same edge
    a_pause_state: assert property (@(posedge clk) disable iff (!rst_n)
        cpu_pause == (state == st_pause))
        else $error("cpu_pause %b disagrees with state %s", cpu_pause, state.name());

endmodule

`default_nettype wire

// File: src/apb_input_regs.sv
`timescale 1ns/1ps
`default_nettype none

module apb_input_regs (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     psel,
    input  logic                     penable,
    input  logic                     pwrite,
    input  keypad_pkg::apb_addr_t    paddr,
    input  keypad_pkg::data_word_t   pwdata,
    output keypad_pkg::data_word_t   prdata,
    output logic                     pready,
    output logic                     pslverr,
    input  keypad_pkg::data_word_t   switches,
    input  logic                     input_complete,
    input  logic                     switch_enable,
    input  logic                     cpu_pause,
    input  keypad_pkg::digit_count_t digit_count,
    input  keypad_pkg::data_word_t   keypad_data,
    output logic                     input_request,
    output logic                     ignore_pause
);
    import keypad_pkg::*;

    logic       access;
    logic       addr_hit;
    logic       write_ctrl;
    logic       entry_active;     // request seen, no confirm yet
    logic       complete_q;
    logic       complete_rise;
    logic       switch_latched;   // switch mode at last confirm
    logic       use_switches;
    data_word_t status_word;

    assign access        = psel && penable;
    assign addr_hit      = (paddr == addr_ctrl) || (paddr == addr_status)
                        || (paddr == addr_data);
    assign write_ctrl    = access && pwrite && (paddr == addr_ctrl);
    assign complete_rise = input_complete && !complete_q;
    assign use_switches  = complete_rise ? switch_enable : switch_latched;   // no lag on confirm
    assign status_word   = {24'b0, digit_count, entry_active, cpu_pause,
                            switch_enable, input_complete};

    assign pready  = 1'b1;   // zero wait states
    assign pslverr = access && !addr_hit;

    always_comb begin
        case (paddr)
            addr_ctrl:   prdata = {30'b0, ignore_pause, 1'b0};   // request bit reads 0
            addr_status: prdata = status_word;
            addr_data:   prdata = use_switches ? switches : keypad_data;
            default:     prdata = '0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            input_request  <= 1'b0;
            ignore_pause   <= 1'b0;
            entry_active   <= 1'b0;
            complete_q     <= 1'b0;
            switch_latched <= 1'b0;
        end else begin
            input_request <= write_ctrl && pwdata[0];   // one-cycle pulse
            complete_q    <= input_complete;
            if (write_ctrl) begin
                ignore_pause <= pwdata[1];
            end
            if (complete_rise) begin
                entry_active   <= 1'b0;
                switch_latched <= switch_enable;
            end else if (input_request) begin
                entry_active   <= 1'b1;
                switch_latched <= 1'b0;
            end
        end
    end

    a_apb_enable: assert property (@(posedge clk) disable iff (!rst_n) penable |-> psel)
        else $error("penable high without psel");

endmodule

`default_nettype wire

// File: src/keypad_input_top.sv
`timescale 1ns/1ps
`default_nettype none

module keypad_input_top #(
    parameter int scan_div       = 1000,
    parameter int debounce_scans = 3
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  keypad_pkg::apb_addr_t  paddr,
    input  keypad_pkg::data_word_t pwdata,
    output keypad_pkg::data_word_t prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  logic [3:0]             kp_row,
    output logic [3:0]             kp_col,
    input  keypad_pkg::data_word_t switches,
    output logic                   cpu_pause,
    output logic                   overflow_9th,
    output logic                   overflow_10th
);
    import keypad_pkg::*;

    logic         key_valid;
    key_code_t    key_code;
    logic         input_request;
    logic         ignore_pause;
    logic         input_complete;
    logic         switch_enable;
    digit_count_t digit_count;
    data_word_t   keypad_data;

    keypad_scanner #(
        .scan_div       (scan_div),
        .debounce_scans (debounce_scans)
    ) u_keypad_scanner (
        .clk       (clk),
        .rst_n     (rst_n),
        .kp_row    (kp_row),
        .kp_col    (kp_col),
        .key_valid (key_valid),
        .key_code  (key_code)
    );

    decimal_entry u_decimal_entry (
        .clk            (clk),
        .rst_n          (rst_n),
        .key_valid      (key_valid),
        .key_code       (key_code),
        .input_request  (input_request),
        .ignore_pause   (ignore_pause),
        .input_complete (input_complete),
        .switch_enable  (switch_enable),
        .cpu_pause      (cpu_pause),
        .digit_count    (digit_count),
        .keypad_data    (keypad_data),
        .overflow_9th   (overflow_9th),
        .overflow_10th  (overflow_10th)
    );

    apb_input_regs u_apb_input_regs (
        .clk            (clk),
        .rst_n          (rst_n),
        .psel           (psel),
        .penable        (penable),
        .pwrite         (pwrite),
        .paddr          (paddr),
        .pwdata         (pwdata),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .switches       (switches),
        .input_complete (input_complete),
        .switch_enable  (switch_enable),
        .cpu_pause      (cpu_pause),
        .digit_count    (digit_count),
        .keypad_data    (keypad_data),
        .input_request  (input_request),
        .ignore_pause   (ignore_pause)
    );

endmodule

`default_nettype wire

// File: test/keypad_model.sv
`timescale 1ns/1ps
`default_nettype none

// 4x4 matrix with at most one key held down
module keypad_model (
    input  logic                  pressed,
    input  keypad_pkg::key_code_t pressed_code,
    input  logic [3:0]            kp_col,
    output logic [3:0]            kp_row
);
    logic [3:0] key_row;
    logic [3:0] key_col;
    logic       col_strobed;

    assign key_row     = pressed_code[7:4];
    assign key_col     = pressed_code[3:0];
    assign col_strobed = |(~kp_col & ~key_col);   // the key's column is driven low

    always_comb begin
        if (pressed && col_strobed) begin
            kp_row = key_row;   // closed switch pulls its row low
        end else begin
            kp_row = 4'b1111;   // pull-ups
        end
    end

endmodule

`default_nettype wire

// File: test/tb_keypad_input.sv
`timescale 1ns/1ps
`default_nettype none

module tb_keypad_input;
    import keypad_pkg::*;

    localparam int hold_cycles    = 40;      // press time, and the same again released
    localparam int timeout_cycles = 40000;   // about 41 presses of 80 cycles plus apb, wide margin

    localparam key_code_t digit_keys [10] = '{key_zero, key_one, key_two, key_three, key_four,
                                              key_five, key_six, key_seven, key_eight, key_nine};

    logic        clk = 1'b0;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    data_word_t  pwdata;
    data_word_t  prdata;
    logic        pready;
    logic        pslverr;
    logic [3:0]  kp_row;
    logic [3:0]  kp_col;
    data_word_t  switches;
    logic        cpu_pause;
    logic        overflow_9th;
    logic        overflow_10th;
    logic        pressed;
    key_code_t   pressed_code;

    logic [31:0] lfsr_state = 32'h0053_dbdb;
    data_word_t  expected_value;   // reference number of the running entry
    int          expected_count;
    data_word_t  switch_value;
    logic [31:0] bits;
    int          key_events = 0;
    int          cycle_count = 0;

    keypad_input_top #(.scan_div(4), .debounce_scans(2)) u_keypad_input_top (.*);

    keypad_model u_keypad_model (.*);

    always #50 clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input data_word_t got, input data_word_t exp);
        assert (got === exp)
            else abort_run($sformatf("mismatch at %0t: %s expected 0x%08h, got 0x%08h",
                                     $time, name, exp, got));
    endtask

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int count, output logic [31:0] value);
        value = '0;
        for (int k = 0; k < count; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic apb_transfer(input logic is_write, input apb_addr_t addr,
                                input data_word_t wdata, input logic err_exp,
                                output data_word_t rdata);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= is_write;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);   // middle of the access cycle
        assert (pready === 1'b1)
            else abort_run($sformatf("pready low in the access cycle to offset 0x%h", addr));
        check_value("pslverr", 32'(pslverr), 32'(err_exp));
        rdata = prdata;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic check_reg(input apb_addr_t addr, input string name, input data_word_t exp);
        data_word_t rd;
        apb_transfer(1'b0, addr, '0, 1'b0, rd);
        check_value(name, rd, exp);
    endtask

    task automatic check_status(input logic active, input logic paused,
                                input logic switch_mode, input logic complete);
        data_word_t exp;
        exp = {24'b0, 4'(expected_count), active, paused, switch_mode, complete};
        check_reg(addr_status, "STATUS", exp);
    endtask

    task automatic check_outputs(input logic pause_exp, input logic ov9_exp, input logic ov10_exp);
        @(negedge clk);
        check_value("cpu_pause", 32'(cpu_pause), 32'(pause_exp));
        check_value("overflow_9th", 32'(overflow_9th), 32'(ov9_exp));
        check_value("overflow_10th", 32'(overflow_10th), 32'(ov10_exp));
    endtask

    // one key down then up, must give exactly one key event
    task automatic press_key(input key_code_t code);
        int events_before;
        events_before = key_events;
        @(posedge clk);
        pressed      <= 1'b1;
        pressed_code <= code;
        repeat (hold_cycles) @(posedge clk);
        pressed <= 1'b0;
        repeat (hold_cycles) @(posedge clk);
        assert (key_events == events_before + 1)
            else abort_run($sformatf("key %b gave %0d key events instead of one",
                                     code, key_events - events_before));
    endtask

    task automatic press_random_digits(input int count);
        logic [31:0] raw;
        logic [3:0]  digit;
        for (int k = 0; k < count; k++) begin
            take_bits(4, raw);
            digit = 4'(raw % 10);
            press_key(digit_keys[digit]);
            if (expected_count < 10) begin   // ten digits at most, the rest is dropped
                expected_value = expected_value * 32'd10 + 32'(digit);
                expected_count++;
            end
        end
    endtask

    task automatic request_entry();
        data_word_t rd;
        apb_transfer(1'b1, addr_ctrl, 32'h1, 1'b0, rd);
        expected_value = '0;
        expected_count = 0;
    endtask

    task automatic confirm_entry();
        press_key(key_enter);
        expected_count = 0;
    endtask

    always @(negedge clk) begin
        if (u_keypad_input_top.key_valid) begin
            key_events <= key_events + 1;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == timeout_cycles) begin
            abort_run($sformatf("timeout, the tests did not end within %0d cycles",
                                timeout_cycles));
        end
    end

    initial begin
        rst_n          <= 1'b0;
        psel           <= 1'b0;
        penable        <= 1'b0;
        pwrite         <= 1'b0;
        paddr          <= '0;
        pwdata         <= '0;
        switches       <= '0;
        pressed        <= 1'b0;
        pressed_code   <= 8'hff;
        expected_value = '0;
        expected_count = 0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        check_value("kp_col", 32'(kp_col), 32'he);   // column 0 strobed in reset
        @(posedge clk);
        rst_n <= 1'b1;
        take_bits(32, switch_value);
        @(posedge clk);
        switches <= switch_value;
        check_status(1'b0, 1'b0, 1'b0, 1'b0);
        check_reg(addr_data, "DATA", '0);

        // random number, then confirm
        request_entry();
        check_status(1'b1, 1'b0, 1'b0, 1'b0);
        take_bits(3, bits);
        press_random_digits(int'(bits) + 1);
        check_status(1'b1, 1'b0, 1'b0, 1'b0);
        check_reg(addr_data, "DATA", expected_value);
        confirm_entry();
        check_status(1'b0, 1'b0, 1'b0, 1'b1);
        check_reg(addr_data, "DATA", expected_value);

        // backspace, the last one with nothing left to delete
        request_entry();
        press_random_digits(2);
        repeat (3) begin
            press_key(key_backspace);
            if (expected_count > 0) begin
                expected_value = expected_value / 32'd10;
                expected_count--;
            end
            check_status(1'b1, 1'b0, 1'b0, 1'b0);
            check_reg(addr_data, "DATA", expected_value);
        end

        // ten digits fill the entry, two more are ignored
        repeat (12) begin
            press_random_digits(1);
            check_outputs(1'b0, expected_count >= 9, expected_count == 10);
        end
        check_status(1'b1, 1'b0, 1'b0, 1'b0);
        check_reg(addr_data, "DATA", expected_value);
        confirm_entry();
        check_status(1'b0, 1'b0, 1'b0, 1'b1);

        // switch mode
        request_entry();
        press_key(key_switch);
        check_status(1'b1, 1'b0, 1'b1, 1'b0);
        confirm_entry();
        check_status(1'b0, 1'b0, 1'b1, 1'b1);
        check_reg(addr_data, "DATA", switch_value);
        request_entry();
        check_status(1'b1, 1'b0, 1'b1, 1'b0);   // flag held until "B" in keypad mode
        press_key(key_switch);
        press_key(key_switch);
        check_status(1'b1, 1'b0, 1'b0, 1'b0);
        press_random_digits(3);
        confirm_entry();
        check_reg(addr_data, "DATA", expected_value);

        // pause, ignored resume, real resume
        request_entry();
        press_random_digits(2);
        press_key(key_pause);
        check_outputs(1'b1, 1'b0, 1'b0);
        check_status(1'b1, 1'b1, 1'b0, 1'b0);
        apb_transfer(1'b1, addr_ctrl, 32'h2, 1'b0, bits);
        check_reg(addr_ctrl, "CTRL", 32'h2);
        press_key(key_pause);
        check_outputs(1'b1, 1'b0, 1'b0);
        apb_transfer(1'b1, addr_ctrl, 32'h0, 1'b0, bits);
        press_key(key_pause);
        check_outputs(1'b0, 1'b0, 1'b0);
        check_status(1'b1, 1'b0, 1'b0, 1'b0);
        press_random_digits(2);
        check_reg(addr_data, "DATA", expected_value);
        confirm_entry();
        check_status(1'b0, 1'b0, 1'b0, 1'b1);

        // unmapped offset
        apb_transfer(1'b0, 4'hc, '0, 1'b1, bits);

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: keypad_input.f
src/keypad_pkg.sv
src/keypad_scanner.sv
src/decimal_entry.sv
src/apb_input_regs.sv
src/keypad_input_top.sv
test/keypad_model.sv
test/tb_keypad_input.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the keypad input testbench with verilator, run it, look for the pass message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_keypad_input -f keypad_input.f -o tb_keypad_input \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/tb_keypad_input | tee /dev/stderr | grep "ALL TESTS PASSED" > /dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
